// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_uart
FILELIST  = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

// File: src/uart_baud_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module uart_baud_gen (
    input  logic                clk,
    input  logic                reset,
    input  uart_pkg::baud_sel_t baud_sel,
    output logic                tick
);

    logic [4:0]          div;
    logic [4:0]          cnt;
    uart_pkg::baud_sel_t sel_q;

    always_comb begin
        case (baud_sel)
            3'd0:    div = 5'(`UART_DIV_0);
            3'd1:    div = 5'(`UART_DIV_1);
            3'd2:    div = 5'(`UART_DIV_2);
            3'd3:    div = 5'(`UART_DIV_3);
            3'd4:    div = 5'(`UART_DIV_4);
            3'd5:    div = 5'(`UART_DIV_5);
            3'd6:    div = 5'(`UART_DIV_6);
            default: div = 5'(`UART_DIV_7);
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt   <= '0;
            tick  <= 1'b0;
            sel_q <= '0;
        end else if (baud_sel != sel_q) begin
            // new rate, start the period over.
            cnt   <= '0;
            tick  <= 1'b0;
            sel_q <= baud_sel;
        end else if (cnt == div - 5'd1) begin
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 5'd1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: src/uart_config_regs.sv
`timescale 1ns/1ns
`default_nettype none

module uart_config_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cfg_req,
    input  uart_pkg::uart_cfg_wr_t cfg_wdata,
    output logic                   cfg_ack,
    output uart_pkg::uart_cfg_t    cfg,
    output logic                   clear_err
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_ack   <= 1'b0;
            cfg       <= '0;
            clear_err <= 1'b0;
        end else begin
            clear_err <= 1'b0;
            if (cfg_req && !cfg_ack) begin
                cfg_ack   <= 1'b1;
                cfg       <= cfg_wdata.cfg;
                clear_err <= cfg_wdata.clear_err;
            end else if (!cfg_req) begin
                // four-phase return to zero.
                cfg_ack <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        $rose(cfg_ack) |-> $past(cfg_req));

endmodule

`default_nettype wire

// File: src/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// character format.
`define UART_DATA_W      8
`define UART_OVERSAMPLE  16
// start, data, parity and stop.
`define UART_FRAME_BITS  11

// ----------------------------------------------------------------------
// clock cycles per oversample tick, one per baud select.
// ----------------------------------------------------------------------
`define UART_DIV_0  1
`define UART_DIV_1  2
`define UART_DIV_2  3
`define UART_DIV_3  4
`define UART_DIV_4  6
`define UART_DIV_5  8
`define UART_DIV_6  12
`define UART_DIV_7  16

`endif

// File: src/uart_controller.sv
`timescale 1ns/1ns
`default_nettype none

module uart_controller (
    input  logic                   clk,
    input  logic                   reset,
    input  uart_pkg::uart_cfg_t    cfg,
    input  logic                   clear_err,
    input  logic                   tx_req,
    input  uart_pkg::byte_t        tx_data,
    output logic                   tx_ack,
    output logic                   rx_req,
    output uart_pkg::byte_t        rx_data,
    input  logic                   rx_ack,
    input  logic                   tx_busy,
    input  logic                   rx_valid,
    input  uart_pkg::rx_frame_t    rx_frame,
    output logic                   tx_start,
    output uart_pkg::byte_t        tx_byte,
    output logic                   rx_enable,
    output logic                   core_reset,
    output uart_pkg::uart_status_t status
);

    uart_pkg::lock_state_e state;
    uart_pkg::lock_state_e state_next;
    logic                  link_up;
    logic                  tx_ok;
    logic                  rx_deliver;

    assign link_up    = (state == uart_pkg::LINK_ENABLED);
    // rx_valid counts as pending, it may lock the link this cycle.
    assign tx_ok      = link_up && cfg.tx_en && !tx_busy && !rx_req && !rx_valid;
    assign rx_deliver = rx_valid && link_up && cfg.rx_en
                        && !rx_frame.perror && !rx_frame.ferror;

    assign rx_enable  = cfg.rx_en;
    assign core_reset = !link_up;
    assign status     = {state, tx_busy};

    // ----------------------------------------------------------------------
    // lockout.
    // ----------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            uart_pkg::LINK_ENABLED: begin
                if (rx_valid && rx_frame.ferror) begin
                    state_next = uart_pkg::LINK_FERROR;
                end else if (rx_valid && rx_frame.perror) begin
                    state_next = uart_pkg::LINK_PERROR;
                end
            end
            uart_pkg::LINK_PERROR,
            uart_pkg::LINK_FERROR: begin
                if (clear_err) begin
                    state_next = uart_pkg::LINK_ENABLED;
                end
            end
            default: state_next = uart_pkg::LINK_ENABLED;
        endcase
    end

    // ----------------------------------------------------------------------
    // host handshakes.
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= uart_pkg::LINK_ENABLED;
            tx_ack   <= 1'b0;
            tx_start <= 1'b0;
            rx_req   <= 1'b0;
        end else begin
            state    <= state_next;
            tx_start <= 1'b0;
            if (tx_req && !tx_ack && tx_ok) begin
                tx_ack   <= 1'b1;
                tx_start <= 1'b1;
            end else if (!tx_req) begin
                tx_ack <= 1'b0;
            end
            if (rx_req && rx_ack) begin
                rx_req <= 1'b0;
            end else if (rx_deliver && !rx_req && !rx_ack) begin
                rx_req <= 1'b1;
            end
        end
    end

    // byte buffers.
    always_ff @(posedge clk) begin
        if (tx_req && !tx_ack && tx_ok) begin
            tx_byte <= tx_data;
        end
        if (rx_deliver && !rx_req && !rx_ack) begin
            rx_data <= rx_frame.data;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        rx_req && !rx_ack |=> rx_req);

    assert property (@(posedge clk) disable iff (reset)
        tx_start |-> state == uart_pkg::LINK_ENABLED);

endmodule

`default_nettype wire

// File: src/uart_pkg.sv
`default_nettype none

`include "uart_consts.svh"

package uart_pkg;

    typedef logic [`UART_DATA_W-1:0] byte_t;
    typedef logic [2:0]              baud_sel_t;

    typedef struct packed {
        baud_sel_t baud_sel;
        logic      tx_en;
        logic      rx_en;
    } uart_cfg_t;

    // value written over the config port.
    typedef struct packed {
        uart_cfg_t cfg;
        logic      clear_err;
    } uart_cfg_wr_t;

    typedef enum logic [1:0] {
        LINK_ENABLED = 2'b00,
        LINK_PERROR  = 2'b01,
        LINK_FERROR  = 2'b10
    } lock_state_e;

    typedef struct packed {
        lock_state_e lock_state;
        logic        tx_busy;
    } uart_status_t;

    typedef struct packed {
        byte_t data;
        logic  perror;
        logic  ferror;
    } rx_frame_t;

endpackage

`default_nettype wire

// File: src/uart_receiver.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module uart_receiver (
    input  logic                clk,
    input  logic                reset,
    input  logic                tick,
    input  logic                rx_enable,
    input  logic                rxd,
    output logic                rx_valid,
    output uart_pkg::rx_frame_t rx_frame
);

    localparam int unsigned      CNT_W       = $clog2(`UART_OVERSAMPLE);
    localparam int unsigned      SAMPLES     = `UART_FRAME_BITS - 1;
    localparam logic [CNT_W-1:0] TICK_MID    = CNT_W'(`UART_OVERSAMPLE / 2 - 1);
    localparam logic [CNT_W-1:0] TICK_LAST   = CNT_W'(`UART_OVERSAMPLE - 1);
    localparam logic [3:0]       SAMPLE_LAST = 4'(SAMPLES - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_BITS
    } rx_state_e;

    rx_state_e          state;
    logic               rxd_meta;
    logic               rxd_sync;
    logic [CNT_W-1:0]   tick_cnt;
    logic [3:0]         bit_cnt;
    logic [SAMPLES-1:0] shreg;
    logic [SAMPLES-1:0] shreg_next;
    logic               sample_now;

    assign sample_now = tick && (state == RX_BITS) && (tick_cnt == TICK_LAST);
    assign shreg_next = {rxd_sync, shreg[SAMPLES-1:1]};

    // ----------------------------------------------------------------------
    // start detect and mid-bit sampling.
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= RX_IDLE;
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rx_valid <= 1'b0;
            if (!rx_enable) begin
                state <= RX_IDLE;
            end else if (tick) begin
                case (state)
                    RX_IDLE: begin
                        if (!rxd_sync) begin
                            state    <= RX_START;
                            tick_cnt <= '0;
                        end
                    end
                    RX_START: begin
                        if (tick_cnt == TICK_MID) begin
                            // glitch if the line is back high.
                            state    <= rxd_sync ? RX_IDLE : RX_BITS;
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                    RX_BITS: begin
                        if (tick_cnt == TICK_LAST) begin
                            tick_cnt <= '0;
                            if (bit_cnt == SAMPLE_LAST) begin
                                state    <= RX_IDLE;
                                rx_valid <= 1'b1;
                            end else begin
                                bit_cnt <= bit_cnt + 4'd1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_now) begin
            shreg <= shreg_next;
        end
        if (sample_now && bit_cnt == SAMPLE_LAST) begin
            rx_frame.data   <= shreg_next[`UART_DATA_W-1:0];
            // even parity over data plus parity bit.
            rx_frame.perror <= ^shreg_next[`UART_DATA_W:0];
            rx_frame.ferror <= ~shreg_next[SAMPLES-1];
        end
    end

    assert property (@(posedge clk) disable iff (reset) rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// File: src/uart_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cfg_req,
    input  uart_pkg::uart_cfg_wr_t cfg_wdata,
    output logic                   cfg_ack,
    input  logic                   tx_req,
    input  uart_pkg::byte_t        tx_data,
    output logic                   tx_ack,
    output logic                   rx_req,
    output uart_pkg::byte_t        rx_data,
    input  logic                   rx_ack,
    output logic                   txd,
    input  logic                   rxd,
    output uart_pkg::uart_status_t status
);

    uart_pkg::uart_cfg_t cfg;
    uart_pkg::rx_frame_t rx_frame;
    uart_pkg::byte_t     tx_byte;
    logic                clear_err;
    logic                tx_start;
    logic                tx_busy;
    logic                rx_valid;
    logic                rx_enable;
    logic                core_reset;
    logic                core_rst;
    logic                tx_tick;
    logic                rx_tick;

    // serial blocks also restart while the link is locked.
    assign core_rst = reset | core_reset;

    uart_config_regs i_config_regs (
        .clk       (clk),
        .reset     (reset),
        .cfg_req   (cfg_req),
        .cfg_wdata (cfg_wdata),
        .cfg_ack   (cfg_ack),
        .cfg       (cfg),
        .clear_err (clear_err)
    );

    uart_controller i_controller (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .clear_err  (clear_err),
        .tx_req     (tx_req),
        .tx_data    (tx_data),
        .tx_ack     (tx_ack),
        .rx_req     (rx_req),
        .rx_data    (rx_data),
        .rx_ack     (rx_ack),
        .tx_busy    (tx_busy),
        .rx_valid   (rx_valid),
        .rx_frame   (rx_frame),
        .tx_start   (tx_start),
        .tx_byte    (tx_byte),
        .rx_enable  (rx_enable),
        .core_reset (core_reset),
        .status     (status)
    );

    uart_baud_gen i_tx_baud (
        .clk      (clk),
        .reset    (reset),
        .baud_sel (cfg.baud_sel),
        .tick     (tx_tick)
    );

    uart_baud_gen i_rx_baud (
        .clk      (clk),
        .reset    (reset),
        .baud_sel (cfg.baud_sel),
        .tick     (rx_tick)
    );

    uart_transmitter i_transmitter (
        .clk      (clk),
        .reset    (core_rst),
        .tick     (tx_tick),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

    uart_receiver i_receiver (
        .clk       (clk),
        .reset     (core_rst),
        .tick      (rx_tick),
        .rx_enable (rx_enable),
        .rxd       (rxd),
        .rx_valid  (rx_valid),
        .rx_frame  (rx_frame)
    );

endmodule

`default_nettype wire

// File: src/uart_transmitter.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module uart_transmitter (
    input  logic            clk,
    input  logic            reset,
    input  logic            tick,
    input  logic            tx_start,
    input  uart_pkg::byte_t tx_byte,
    output logic            txd,
    output logic            tx_busy
);

    localparam int unsigned      CNT_W     = $clog2(`UART_OVERSAMPLE);
    localparam int unsigned      SHIFT_W   = `UART_FRAME_BITS - 1;
    localparam logic [CNT_W-1:0] TICK_LAST = CNT_W'(`UART_OVERSAMPLE - 1);
    localparam logic [3:0]       BIT_LAST  = 4'(`UART_FRAME_BITS - 1);

    logic [CNT_W-1:0]   tick_cnt;
    logic [3:0]         bit_cnt;
    logic [SHIFT_W-1:0] shreg;
    logic               load;
    logic               bit_end;

    assign load    = tx_start && !tx_busy;
    assign bit_end = tx_busy && tick && (tick_cnt == TICK_LAST);

    // ----------------------------------------------------------------------
    // bit timing.
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_busy  <= 1'b0;
            txd      <= 1'b1;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (load) begin
            // start bit goes out right away.
            tx_busy  <= 1'b1;
            txd      <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (tx_busy && tick) begin
            if (tick_cnt == TICK_LAST) begin
                tick_cnt <= '0;
                if (bit_cnt == BIT_LAST) begin
                    tx_busy <= 1'b0;
                    txd     <= 1'b1;
                end else begin
                    txd     <= shreg[0];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    // data, even parity and stop wait here, LSB first.
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= {1'b1, ^tx_byte, tx_byte};
        end else if (bit_end && bit_cnt != BIT_LAST) begin
            shreg <= {1'b1, shreg[SHIFT_W-1:1]};
        end
    end

    // line must idle high between frames.
    assert property (@(posedge clk) disable iff (reset) !tx_busy |-> txd);

endmodule

`default_nettype wire

// File: testbench/tb_uart.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module tb_uart;

    localparam int NUM_ROWS = 13;
    localparam int MARGIN   = 4000;

    typedef struct packed {
        logic [127:0]          name;
        uart_pkg::baud_sel_t   baud;
        logic                  tx_en;
        logic                  rx_en;
        logic                  clear;
        logic                  hold;
        logic                  blocked;
        logic                  use_lfsr;
        uart_pkg::byte_t       data;
        logic [1:0]            corrupt;
        logic                  exp_deliver;
        uart_pkg::lock_state_e exp_state;
    } row_t;

    logic                   clk;
    logic                   reset;
    logic                   cfg_req;
    logic                   cfg_ack;
    uart_pkg::uart_cfg_wr_t cfg_wdata;
    logic                   tx_req;
    logic                   tx_ack;
    uart_pkg::byte_t        tx_data;
    logic                   rx_req;
    logic                   rx_ack;
    uart_pkg::byte_t        rx_data;
    logic                   txd;
    logic                   rxd;
    uart_pkg::uart_status_t status;

    row_t                  rows [NUM_ROWS];
    logic [31:0]           lfsr;
    int                    cur_div;
    logic [1:0]            cur_corrupt;
    int                    line_cnt;
    logic                  line_active;
    int                    row_idx;
    logic [127:0]          row_name;
    logic                  row_start;
    logic                  row_done;
    logic                  ack_window;
    logic                  report;
    logic                  exp_deliver;
    logic                  exp_sent;
    uart_pkg::byte_t       exp_byte;
    uart_pkg::lock_state_e exp_state;
    int                    hs_errors;
    int                    fail_count;

    uart_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .cfg_req   (cfg_req),
        .cfg_wdata (cfg_wdata),
        .cfg_ack   (cfg_ack),
        .tx_req    (tx_req),
        .tx_data   (tx_data),
        .tx_ack    (tx_ack),
        .rx_req    (rx_req),
        .rx_data   (rx_data),
        .rx_ack    (rx_ack),
        .txd       (txd),
        .rxd       (rxd),
        .status    (status)
    );

    uart_checker i_checker (
        .clk         (clk),
        .reset       (reset),
        .rx_req      (rx_req),
        .rx_data     (rx_data),
        .tx_ack      (tx_ack),
        .status      (status),
        .row_idx     (row_idx),
        .row_name    (row_name),
        .row_start   (row_start),
        .row_done    (row_done),
        .ack_window  (ack_window),
        .exp_deliver (exp_deliver),
        .exp_sent    (exp_sent),
        .exp_byte    (exp_byte),
        .exp_state   (exp_state),
        .hs_errors   (hs_errors),
        .report      (report),
        .fail_count  (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int divisor_of(input uart_pkg::baud_sel_t sel);
        case (sel)
            3'd0:    return `UART_DIV_0;
            3'd1:    return `UART_DIV_1;
            3'd2:    return `UART_DIV_2;
            3'd3:    return `UART_DIV_3;
            3'd4:    return `UART_DIV_4;
            3'd5:    return `UART_DIV_5;
            3'd6:    return `UART_DIV_6;
            default: return `UART_DIV_7;
        endcase
    endfunction

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic uart_pkg::byte_t lfsr_byte();
        uart_pkg::byte_t b;
        for (int k = 0; k < 8; k++) begin
            lfsr = lfsr_next(lfsr);
            b[k] = lfsr[0];
        end
        return b;
    endfunction

    function automatic row_t make_row(input logic [127:0] name, input logic [2:0] baud,
                                      input logic tx_en, input logic rx_en,
                                      input logic clear, input logic hold,
                                      input logic blocked, input logic use_lfsr,
                                      input logic [7:0] data, input logic [1:0] corrupt,
                                      input logic dlv, input uart_pkg::lock_state_e st);
        return {name, baud, tx_en, rx_en, clear, hold, blocked, use_lfsr, data, corrupt,
                dlv, st};
    endfunction

    // ----------------------------------------------------------------------
    // stimulus table.
    // corrupt bit 0 flips parity, bit 1 forces the stop bit low.
    // ----------------------------------------------------------------------
    initial begin
        rows[0]  = make_row("loop_b0_fixed", 3'd0, 1, 1, 0, 0, 0, 0, 8'ha5, 2'd0, 1,
                            uart_pkg::LINK_ENABLED);
        rows[1]  = make_row("loop_b3_lfsr", 3'd3, 1, 1, 0, 0, 0, 1, 8'h00, 2'd0, 1,
                            uart_pkg::LINK_ENABLED);
        rows[2]  = make_row("loop_b7_lfsr", 3'd7, 1, 1, 0, 0, 0, 1, 8'h00, 2'd0, 1,
                            uart_pkg::LINK_ENABLED);
        rows[3]  = make_row("loop_b7_fixed", 3'd7, 1, 1, 0, 0, 0, 0, 8'h3c, 2'd0, 1,
                            uart_pkg::LINK_ENABLED);
        rows[4]  = make_row("tx_disabled", 3'd3, 1, 1, 0, 1, 0, 0, 8'h5a, 2'd0, 1,
                            uart_pkg::LINK_ENABLED);
        rows[5]  = make_row("rx_disabled", 3'd3, 1, 0, 0, 0, 0, 0, 8'hc3, 2'd0, 0,
                            uart_pkg::LINK_ENABLED);
        rows[6]  = make_row("parity_err", 3'd3, 1, 1, 0, 0, 0, 1, 8'h00, 2'd1, 0,
                            uart_pkg::LINK_PERROR);
        rows[7]  = make_row("locked_write", 3'd3, 1, 1, 0, 0, 1, 0, 8'h81, 2'd0, 0,
                            uart_pkg::LINK_PERROR);
        rows[8]  = make_row("clear_b3", 3'd3, 1, 1, 1, 0, 0, 1, 8'h00, 2'd0, 1,
                            uart_pkg::LINK_ENABLED);
        rows[9]  = make_row("stop_err", 3'd0, 1, 1, 0, 0, 0, 0, 8'hff, 2'd2, 0,
                            uart_pkg::LINK_FERROR);
        rows[10] = make_row("clear_b0", 3'd0, 1, 1, 1, 0, 0, 0, 8'h01, 2'd0, 1,
                            uart_pkg::LINK_ENABLED);
        rows[11] = make_row("both_err", 3'd7, 1, 1, 0, 0, 0, 1, 8'h00, 2'd3, 0,
                            uart_pkg::LINK_FERROR);
        rows[12] = make_row("clear_b7", 3'd7, 1, 1, 1, 0, 0, 1, 8'h00, 2'd0, 1,
                            uart_pkg::LINK_ENABLED);
    end

    // ----------------------------------------------------------------------
    // txd loops back to rxd and may be corrupted.
    // ----------------------------------------------------------------------
    always @(negedge clk) begin : line_model
        int   bit_len;
        int   idx;
        int   phase;
        logic in_win;
        bit_len = `UART_OVERSAMPLE * cur_div;
        if (reset) begin
            line_active = 1'b0;
            line_cnt    = 0;
        end else if (!line_active && !txd) begin
            line_active = 1'b1;
            line_cnt    = 0;
        end else if (line_active) begin
            line_cnt = line_cnt + 1;
            if (line_cnt >= `UART_FRAME_BITS * bit_len) begin
                line_active = 1'b0;
            end
        end
        idx    = line_cnt / bit_len;
        phase  = line_cnt % bit_len;
        // keep clear of the bit edges.
        in_win = line_active && phase >= bit_len / 8 && phase < bit_len - bit_len / 8;
        rxd    = reset ? 1'b1 : txd;
        if (in_win && idx == 9 && cur_corrupt[0]) begin
            rxd = !txd;
        end
        if (in_win && idx == 10 && cur_corrupt[1]) begin
            rxd = 1'b0;
        end
    end

    task automatic wait_timeout(input string what);
        $display("wait timed out in row %0d: %s", row_idx, what);
        hs_errors = hs_errors + 1;
    endtask

    task automatic write_config(input uart_pkg::uart_cfg_wr_t word);
        int n;
        cfg_wdata = word;
        cfg_req   = 1'b1;
        n         = 0;
        while (!cfg_ack && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (!cfg_ack) begin
            wait_timeout("cfg_ack did not rise");
        end
        cfg_req = 1'b0;
        n       = 0;
        while (cfg_ack && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (cfg_ack) begin
            wait_timeout("cfg_ack did not drop");
        end
    endtask

    task automatic run_row(input int i);
        row_t            r;
        uart_pkg::byte_t data;
        int              frame;
        int              n;
        r     = rows[i];
        frame = `UART_OVERSAMPLE * `UART_FRAME_BITS * divisor_of(r.baud);
        data  = r.use_lfsr ? lfsr_byte() : r.data;
        @(negedge clk);
        row_idx     = i;
        row_name    = r.name;
        exp_deliver = r.exp_deliver;
        exp_sent    = !r.blocked;
        exp_byte    = data;
        exp_state   = r.exp_state;
        cur_div     = divisor_of(r.baud);
        cur_corrupt = r.corrupt;
        row_start   = 1'b1;
        @(negedge clk);
        row_start = 1'b0;
        write_config({r.baud, r.tx_en & !r.hold, r.rx_en, r.clear});
        tx_data = data;
        tx_req  = 1'b1;
        // tx_ack must stay low for a whole frame.
        if (r.hold || r.blocked) begin
            ack_window = 1'b1;
            repeat (frame) @(negedge clk);
            ack_window = 1'b0;
        end
        if (r.blocked) begin
            tx_req = 1'b0;
        end else begin
            if (r.hold) begin
                write_config({r.baud, 1'b1, r.rx_en, 1'b0});
            end
            n = 0;
            while (!tx_ack && n < frame) begin
                @(negedge clk);
                n++;
            end
            if (!tx_ack) begin
                wait_timeout("tx_ack did not rise");
            end
            tx_req = 1'b0;
            n      = 0;
            while (tx_ack && n < 16) begin
                @(negedge clk);
                n++;
            end
            if (tx_ack) begin
                wait_timeout("tx_ack did not drop");
            end
        end
        n = 0;
        while (!rx_req && n < 2 * frame) begin
            @(negedge clk);
            n++;
        end
        if (rx_req) begin
            rx_ack = 1'b1;
            n      = 0;
            while (rx_req && n < 16) begin
                @(negedge clk);
                n++;
            end
            if (rx_req) begin
                wait_timeout("rx_req did not drop after rx_ack");
            end
            rx_ack = 1'b0;
        end
        n = 0;
        while (status.tx_busy && n < frame) begin
            @(negedge clk);
            n++;
        end
        if (status.tx_busy) begin
            wait_timeout("tx_busy did not drop after the frame");
        end
        row_done = 1'b1;
        @(negedge clk);
        row_done = 1'b0;
    endtask

    initial begin : stimulus
        reset       = 1'b1;
        cfg_req     = 1'b0;
        cfg_wdata   = '0;
        tx_req      = 1'b0;
        tx_data     = '0;
        rx_ack      = 1'b0;
        rxd         = 1'b1;
        lfsr        = 32'hee3a;
        cur_div     = 1;
        cur_corrupt = 2'd0;
        line_active = 1'b0;
        line_cnt    = 0;
        row_idx     = 0;
        row_name    = '0;
        row_start   = 1'b0;
        row_done    = 1'b0;
        ack_window  = 1'b0;
        report      = 1'b0;
        exp_deliver = 1'b0;
        exp_sent    = 1'b0;
        exp_byte    = '0;
        exp_state   = uart_pkg::LINK_ENABLED;
        hs_errors   = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        @(negedge clk);
        report = 1'b1;
        @(negedge clk);
        report = 1'b0;
        @(negedge clk);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // three frame times per row is the worst case.
    initial begin : watchdog
        longint limit;
        #1;
        limit = MARGIN;
        for (int i = 0; i < NUM_ROWS; i++) begin
            limit = limit + 16 * divisor_of(rows[i].baud) * 11 * 3;
        end
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", limit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/uart_checker.sv
`timescale 1ns/1ns
`default_nettype none

module uart_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rx_req,
    input  uart_pkg::byte_t        rx_data,
    input  logic                   tx_ack,
    input  uart_pkg::uart_status_t status,
    input  int                     row_idx,
    input  logic [127:0]           row_name,
    input  logic                   row_start,
    input  logic                   row_done,
    input  logic                   ack_window,
    input  logic                   exp_deliver,
    input  logic                   exp_sent,
    input  uart_pkg::byte_t        exp_byte,
    input  uart_pkg::lock_state_e  exp_state,
    input  int                     hs_errors,
    input  logic                   report,
    output int                     fail_count
);

    logic            rx_req_q;
    int              deliveries;
    uart_pkg::byte_t got_byte;
    logic            ack_leak;
    logic            busy_seen;
    int              hs_at_start;
    int              rows_run;
    int              rows_failed;

    assign fail_count = rows_failed + hs_errors;

    initial begin
        rx_req_q    = 1'b0;
        deliveries  = 0;
        got_byte    = '0;
        ack_leak    = 1'b0;
        busy_seen   = 1'b0;
        hs_at_start = 0;
        rows_run    = 0;
        rows_failed = 0;
    end

    always @(posedge clk) begin : compare
        logic bad;
        int   exp_count;
        bad = 1'b0;
        if (row_start) begin
            deliveries  = 0;
            ack_leak    = 1'b0;
            busy_seen   = 1'b0;
            hs_at_start = hs_errors;
        end
        if (!reset && rx_req && !rx_req_q) begin
            deliveries = deliveries + 1;
            got_byte   = rx_data;
        end
        if (ack_window && tx_ack) begin
            ack_leak = 1'b1;
        end
        if (!reset && status.tx_busy) begin
            busy_seen = 1'b1;
        end
        if (row_done) begin
            exp_count = exp_deliver ? 1 : 0;
            if (deliveries != exp_count) begin
                $display("CHECK FAILED %0s: deliveries expected %0d actual %0d",
                         row_name, exp_count, deliveries);
                bad = 1'b1;
            end else if (exp_deliver && got_byte !== exp_byte) begin
                $display("CHECK FAILED %0s: rx_data expected %02h actual %02h",
                         row_name, exp_byte, got_byte);
                bad = 1'b1;
            end
            if (status.lock_state !== exp_state) begin
                $display("CHECK FAILED %0s: lock state expected %0d actual %0d",
                         row_name, exp_state, status.lock_state);
                bad = 1'b1;
            end
            if (busy_seen !== exp_sent) begin
                $display("CHECK FAILED %0s: tx_busy seen expected %0b actual %0b",
                         row_name, exp_sent, busy_seen);
                bad = 1'b1;
            end
            if (ack_leak) begin
                $display("row %0d %0s: tx_ack rose while the write should be held off",
                         row_idx, row_name);
                bad = 1'b1;
            end
            if (hs_errors != hs_at_start) begin
                bad = 1'b1;
            end
            rows_run = rows_run + 1;
            if (bad) begin
                rows_failed = rows_failed + 1;
            end
            $display("row %0d %0s: %0s", row_idx, row_name, bad ? "failed" : "ok");
        end
        if (report) begin
            $display("rows run %0d, rows failed %0d, wait timeouts %0d",
                     rows_run, rows_failed, hs_errors);
        end
        rx_req_q = reset ? 1'b0 : rx_req;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
src/uart_pkg.sv
src/uart_baud_gen.sv
src/uart_transmitter.sv
src/uart_receiver.sv
src/uart_config_regs.sv
src/uart_controller.sv
src/uart_top.sv
testbench/uart_checker.sv
testbench/tb_uart.sv
